// File: hdl/frer_pkg.sv
package frer_pkg;

    // port side
    localparam int NUM_PORTS  = 4;
    localparam int PORT_IDX_W = 2;

    // R-tag fields
    localparam int SEQ_W    = 16;
    localparam int HANDLE_W = 4;

    // stream table depth, one entry per handle value
    localparam int NUM_STREAMS = 16;

    // sequence value that never matches, judged as finish only
    localparam logic [SEQ_W-1:0] INVALID_SEQ = '1;

    // ticks a stream stays out of take-any after its last accepted frame
    localparam logic [15:0] RESET_TICKS = 16'd50;

    typedef logic [NUM_PORTS-1:0] port_mask_t;  // one bit per switch port

    typedef struct packed {
        logic [SEQ_W-1:0]    seq_num;  // R-tag sequence number
        logic [HANDLE_W-1:0] handle;   // stream handle, indexes the table
    } tag_info_t;

    // outcome of one match decision
    typedef enum logic [1:0] {
        VERDICT_NONE    = 2'd0,  // invalid sequence, finish only
        VERDICT_PASS    = 2'd1,
        VERDICT_DISCARD = 2'd2
    } verdict_e;

    // sequencing of one judged tag
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_LOOKUP = 2'd1,
        ST_DECIDE = 2'd2,
        ST_REPORT = 2'd3
    } ctrl_state_e;

endpackage

// File: hdl/tag_capture.sv
`timescale 1ns/1ps

module tag_capture (
    input  logic                                             i_clk,
    input  logic                                             i_rst,
    input  frer_pkg::port_mask_t                             i_tag_valid,  // one-cycle strobes
    input  frer_pkg::tag_info_t [frer_pkg::NUM_PORTS-1:0]    i_tag,
    input  frer_pkg::port_mask_t                             i_clear,      // from report stage
    input  logic [frer_pkg::PORT_IDX_W-1:0]                  i_grant_idx,
    output frer_pkg::port_mask_t                             o_pending,
    output frer_pkg::tag_info_t                              o_sel_tag
);

    import frer_pkg::*;

    tag_info_t  r_tag [NUM_PORTS];  // holding register per port
    port_mask_t r_pending;
    tag_info_t  r_sel_tag;

    // a tag is kept until its port is judged
    // a new strobe on a busy port simply overwrites it
    always_ff @(posedge i_clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (i_tag_valid[p]) begin
                r_tag[p] <= i_tag[p];
            end
        end
    end

    // pending level per port
    // set on strobe, dropped by clear, strobe wins a tie
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_pending <= '0;
        end else begin
            r_pending <= (r_pending & ~i_clear) | i_tag_valid;
        end
    end

    // lookup stage register
    // grant index is stable from idle onwards, so the tag is ready in decide
    always_ff @(posedge i_clk) begin
        r_sel_tag <= r_tag[i_grant_idx];
    end

    assign o_pending = r_pending;
    assign o_sel_tag = r_sel_tag;

endmodule

// File: hdl/recovery_ctrl.sv
`timescale 1ns/1ps

module recovery_ctrl (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  frer_pkg::port_mask_t             i_pending,
    input  frer_pkg::verdict_e               i_verdict,     // valid during report
    output logic [frer_pkg::PORT_IDX_W-1:0]  o_grant_idx,
    output logic                             o_decide,
    output frer_pkg::port_mask_t             o_clear,
    output frer_pkg::port_mask_t             o_pass_en,
    output frer_pkg::port_mask_t             o_discard_en,
    output frer_pkg::port_mask_t             o_judge_finish
);

    import frer_pkg::*;

    ctrl_state_e             r_state;
    logic [PORT_IDX_W-1:0]   r_grant_idx;  // also the last served port
    port_mask_t              r_finish;
    logic [PORT_IDX_W-1:0]   cand_idx;
    logic [PORT_IDX_W-1:0]   next_idx;
    logic                    next_found;

    // round-robin search, starting one past the last served port
    always_comb begin
        next_found = 1'b0;
        next_idx   = r_grant_idx;
        cand_idx   = r_grant_idx;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand_idx = r_grant_idx + PORT_IDX_W'(k);  // wraps on the index width
            if (!next_found && i_pending[cand_idx]) begin
                next_found = 1'b1;
                next_idx   = cand_idx;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state     <= ST_IDLE;
            r_grant_idx <= PORT_IDX_W'(NUM_PORTS - 1);  // first search starts at port 0
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (next_found) begin
                        r_grant_idx <= next_idx;
                        r_state     <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: r_state <= ST_DECIDE;  // tag mux registers here
                ST_DECIDE: r_state <= ST_REPORT;
                default:   r_state <= ST_IDLE;
            endcase
        end
    end

    // one-hot finish, raised for the single report cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_finish <= '0;
        end else if (r_state == ST_DECIDE) begin
            r_finish <= port_mask_t'(1'b1) << r_grant_idx;
        end else begin
            r_finish <= '0;
        end
    end

    assign o_grant_idx    = r_grant_idx;
    assign o_decide       = (r_state == ST_DECIDE);
    assign o_clear        = r_finish;  // pending drops as the report ends
    assign o_judge_finish = r_finish;

    // verdict register lands together with the finish register
    assign o_pass_en    = r_finish & {NUM_PORTS{i_verdict == VERDICT_PASS}};
    assign o_discard_en = r_finish & {NUM_PORTS{i_verdict == VERDICT_DISCARD}};

endmodule

// File: hdl/stream_table.sv
`timescale 1ns/1ps

module stream_table (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  frer_pkg::tag_info_t                i_tag,            // granted tag, valid in decide
    input  logic                               i_decide,
    input  logic [frer_pkg::NUM_STREAMS-1:0]   i_expired,        // timer pulses
    output frer_pkg::verdict_e                 o_verdict,
    output logic                               o_reload,
    output logic [frer_pkg::HANDLE_W-1:0]      o_reload_handle
);

    import frer_pkg::*;

    logic [SEQ_W-1:0]       r_recov_seq [NUM_STREAMS];  // recovery sequence number per stream
    logic [NUM_STREAMS-1:0] r_take_any;
    verdict_e               r_verdict;
    logic                   r_reload;
    logic [HANDLE_W-1:0]    r_reload_handle;

    logic     seq_valid;
    logic     take_any_hit;
    logic     dup_hit;
    logic     accept;
    verdict_e verdict_next;

    assign seq_valid    = (i_tag.seq_num != INVALID_SEQ);
    assign take_any_hit = r_take_any[i_tag.handle];
    assign dup_hit      = (i_tag.seq_num == r_recov_seq[i_tag.handle]);  // equality only

    // match recovery rules in priority order
    always_comb begin
        if (!seq_valid) begin
            verdict_next = VERDICT_NONE;  // no state change at all
        end else if (take_any_hit) begin
            verdict_next = VERDICT_PASS;
        end else if (dup_hit) begin
            verdict_next = VERDICT_DISCARD;
        end else begin
            verdict_next = VERDICT_PASS;
        end
    end

    assign accept = i_decide && (verdict_next == VERDICT_PASS);

    // stored number follows every accepted frame
    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_recov_seq[i_tag.handle] <= i_tag.seq_num;
        end
    end

    // expiry opens take-any, an accepted frame closes it
    // an accept in the same cycle wins since the timer restarts with it
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_take_any <= '1;  // every stream starts in take-any
        end else begin
            r_take_any <= r_take_any | i_expired;
            if (accept) begin
                r_take_any[i_tag.handle] <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_verdict <= VERDICT_NONE;
            r_reload  <= 1'b0;
        end else begin
            if (i_decide) begin
                r_verdict <= verdict_next;  // held until the next decide
            end
            r_reload <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_reload_handle <= i_tag.handle;
        end
    end

    assign o_verdict       = r_verdict;
    assign o_reload        = r_reload;
    assign o_reload_handle = r_reload_handle;

endmodule

// File: hdl/stream_timer_bank.sv
`timescale 1ns/1ps

module stream_timer_bank (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_reload,
    input  logic [frer_pkg::HANDLE_W-1:0]      i_reload_handle,
    output logic [frer_pkg::NUM_STREAMS-1:0]   o_expired
);

    import frer_pkg::*;

    localparam int TICK_W = $bits(RESET_TICKS);

    logic [TICK_W-1:0]      r_ticks [NUM_STREAMS];  // remaining ticks per stream
    logic [NUM_STREAMS-1:0] r_active;
    logic [NUM_STREAMS-1:0] r_expired;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_active  <= '0;
            r_expired <= '0;
            for (int s = 0; s < NUM_STREAMS; s++) begin
                r_ticks[s] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_STREAMS; s++) begin
                r_expired[s] <= 1'b0;
                if (i_reload && (i_reload_handle == HANDLE_W'(s))) begin
                    r_ticks[s]  <= RESET_TICKS;  // restart on every accepted frame
                    r_active[s] <= 1'b1;
                end else if (r_active[s]) begin
                    if (r_ticks[s] == '0) begin
                        // single pulse, then idle until the next reload
                        r_active[s]  <= 1'b0;
                        r_expired[s] <= 1'b1;
                    end else begin
                        r_ticks[s] <= r_ticks[s] - 1'b1;
                    end
                end
            end
        end
    end

    assign o_expired = r_expired;

endmodule

// File: hdl/match_recovery_top.sv
`timescale 1ns/1ps

module match_recovery_top (
    input  logic                                           i_clk,
    input  logic                                           i_rst,
    input  frer_pkg::port_mask_t                           i_tag_valid,
    input  frer_pkg::tag_info_t [frer_pkg::NUM_PORTS-1:0]  i_tag,
    output frer_pkg::port_mask_t                           o_pass_en,
    output frer_pkg::port_mask_t                           o_discard_en,
    output frer_pkg::port_mask_t                           o_judge_finish
);

    import frer_pkg::*;

    port_mask_t             pending;
    port_mask_t             clear;
    logic [PORT_IDX_W-1:0]  grant_idx;
    tag_info_t              sel_tag;
    logic                   decide;
    verdict_e               verdict;
    logic                   reload;
    logic [HANDLE_W-1:0]    reload_handle;
    logic [NUM_STREAMS-1:0] expired;

    tag_capture u_tag_capture (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tag_valid (i_tag_valid),
        .i_tag       (i_tag),
        .i_clear     (clear),
        .i_grant_idx (grant_idx),
        .o_pending   (pending),
        .o_sel_tag   (sel_tag)
    );

    recovery_ctrl u_recovery_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_pending      (pending),
        .i_verdict      (verdict),
        .o_grant_idx    (grant_idx),
        .o_decide       (decide),
        .o_clear        (clear),
        .o_pass_en      (o_pass_en),
        .o_discard_en   (o_discard_en),
        .o_judge_finish (o_judge_finish)
    );

    stream_table u_stream_table (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_tag           (sel_tag),
        .i_decide        (decide),
        .i_expired       (expired),
        .o_verdict       (verdict),
        .o_reload        (reload),
        .o_reload_handle (reload_handle)
    );

    stream_timer_bank u_stream_timer_bank (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_reload        (reload),
        .i_reload_handle (reload_handle),
        .o_expired       (expired)
    );

endmodule

// File: verification/match_recovery_assert.sv
`timescale 1ns/1ps

module match_recovery_assert (
    input logic                 i_clk,
    input logic                 i_rst,
    input frer_pkg::port_mask_t i_pass_en,
    input frer_pkg::port_mask_t i_discard_en,
    input frer_pkg::port_mask_t i_judge_finish
);

    // one port reported per cycle at most
    finish_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(i_judge_finish))
        else $error("o_judge_finish not one-hot: %h", i_judge_finish);

    verdict_in_finish: assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_pass_en | i_discard_en) & ~i_judge_finish) == '0)
        else $error("verdict outside finish: pass %h discard %h finish %h",
                    i_pass_en, i_discard_en, i_judge_finish);

    pass_xor_discard: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_pass_en & i_discard_en) == '0)
        else $error("pass and discard together: %h %h", i_pass_en, i_discard_en);

    quiet_in_reset: assert property (@(posedge i_clk)
        $past(i_rst) |-> (i_judge_finish == '0 && i_pass_en == '0 && i_discard_en == '0))
        else $error("outputs active during reset");  // registers settle one edge into reset

endmodule

bind match_recovery_top match_recovery_assert u_match_recovery_assert (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_pass_en      (o_pass_en),
    .i_discard_en   (o_discard_en),
    .i_judge_finish (o_judge_finish)
);

// File: verification/tb_match_recovery.sv
`timescale 1ns/1ps

module tb_match_recovery;

    import frer_pkg::*;

    localparam int WAIT_LIMIT = 4 * NUM_PORTS + 8;  // all four ports pending

    typedef struct packed {
        logic [31:0]               gap;
        logic                      filler;  // random idle cycles allowed before it
        port_mask_t                mask;
        tag_info_t [NUM_PORTS-1:0] tags;
        logic [8*NUM_PORTS-1:0]    codes;   // one letter per port, port 0 leftmost
    } case_t;

    logic                      i_clk;
    logic                      i_rst;
    port_mask_t                i_tag_valid;
    tag_info_t [NUM_PORTS-1:0] i_tag;
    port_mask_t                o_pass_en;
    port_mask_t                o_discard_en;
    port_mask_t                o_judge_finish;

    case_t cases [$];
    int    value_errors = 0;
    int    other_errors = 0;
    int    cycle_count = 0;
    int    timeout_limit = 32'h7fff_ffff;  // replaced once the cases are loaded

    match_recovery_top u_match_recovery_top (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_tag_valid    (i_tag_valid),
        .i_tag          (i_tag),
        .o_pass_en      (o_pass_en),
        .o_discard_en   (o_discard_en),
        .o_judge_finish (o_judge_finish)
    );

    always #10 i_clk = ~i_clk;

    // watchdog
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not complete within %0d cycles", timeout_limit);
            $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        int          gap_raw;
        int          flag_raw;
        logic [31:0] mask_raw;
        logic [31:0] hnd [NUM_PORTS];
        logic [31:0] seq [NUM_PORTS];
        logic [31:0] code_raw;
        case_t       c;
        fd = $fopen("verification/recovery_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/recovery_cases.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;  // comment or end of file
            n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %s", gap_raw, flag_raw, mask_raw,
                        hnd[0], seq[0], hnd[1], seq[1], hnd[2], seq[2], hnd[3], seq[3], code_raw);
            if (n == 12) begin
                c.gap    = gap_raw;
                c.filler = (flag_raw != 0);
                c.mask   = mask_raw[NUM_PORTS-1:0];
                for (int p = 0; p < NUM_PORTS; p++) begin
                    c.tags[p].seq_num = seq[p][SEQ_W-1:0];
                    c.tags[p].handle  = hnd[p][HANDLE_W-1:0];
                end
                c.codes = code_raw;
                cases.push_back(c);
            end else if (n > 0) begin
                $display("malformed line in case file: %s", line);
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    // idle cycles, no finish may show up
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge i_clk);
            assert (o_judge_finish == '0) else begin
                $display("** Error idle: o_judge_finish got %h expected %h", o_judge_finish, 4'h0);
                value_errors++;
            end
        end
    endtask

    task automatic run_case(input case_t c, input int idx);
        int         fin_cnt [NUM_PORTS];
        port_mask_t got_pass;
        port_mask_t got_disc;
        port_mask_t seen;
        logic [7:0] code;
        logic       exp_pass;
        logic       exp_disc;
        int         waited;
        int         e_ports;
        int         e_pass;
        int         e_disc;
        got_pass = '0;
        got_disc = '0;
        seen     = '0;
        waited   = 0;
        e_ports  = 0;
        e_pass   = 0;
        e_disc   = 0;
        for (int p = 0; p < NUM_PORTS; p++) fin_cnt[p] = 0;
        i_tag_valid = c.mask;  // all ports of the case in one cycle
        i_tag       = c.tags;
        while ((seen & c.mask) != c.mask && waited < WAIT_LIMIT) begin
            @(negedge i_clk);
            i_tag_valid = '0;
            waited++;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (o_judge_finish[p]) begin
                    fin_cnt[p]++;
                    seen[p] = 1'b1;
                    if (o_pass_en[p]) got_pass[p] = 1'b1;
                    if (o_discard_en[p]) got_disc[p] = 1'b1;
                end
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            code = c.codes[8*(NUM_PORTS-1-p) +: 8];
            if (!c.mask[p]) begin
                assert (fin_cnt[p] == 0) else begin
                    $display("** Error case %0d: o_judge_finish[%0d] count got %h expected %h",
                             idx, p, fin_cnt[p], 0);
                    value_errors++;
                end
            end else if (fin_cnt[p] == 0) begin
                $display("case %0d: port %0d was strobed but got no finish within %0d cycles",
                         idx, p, WAIT_LIMIT);
                other_errors++;
            end else begin
                assert (fin_cnt[p] == 1) else begin
                    $display("** Error case %0d: o_judge_finish[%0d] count got %h expected %h",
                             idx, p, fin_cnt[p], 1);
                    value_errors++;
                end
                if (code == "E") begin
                    e_ports++;
                    if (got_pass[p]) e_pass++;
                    if (got_disc[p]) e_disc++;
                    // each port of the pair gets exactly one of the two verdicts
                    assert (got_disc[p] == !got_pass[p]) else begin
                        $display("** Error case %0d: o_discard_en[%0d] got %h expected %h",
                                 idx, p, got_disc[p], !got_pass[p]);
                        value_errors++;
                    end
                end else if (code == "P" || code == "D" || code == "N") begin
                    exp_pass = (code == "P");
                    exp_disc = (code == "D");
                    assert (got_pass[p] == exp_pass) else begin
                        $display("** Error case %0d: o_pass_en[%0d] got %h expected %h",
                                 idx, p, got_pass[p], exp_pass);
                        value_errors++;
                    end
                    assert (got_disc[p] == exp_disc) else begin
                        $display("** Error case %0d: o_discard_en[%0d] got %h expected %h",
                                 idx, p, got_disc[p], exp_disc);
                        value_errors++;
                    end
                end else begin
                    $display("case %0d: unknown expected code on port %0d", idx, p);
                    other_errors++;
                end
            end
        end
        // duplicate pair, exactly one pass and one discard
        if (e_ports > 0) begin
            assert (e_ports == 2 && e_pass == 1 && e_disc == 1) else begin
                $display("** Error case %0d: o_pass_en/o_discard_en got %h/%h expected %h/%h",
                         idx, e_pass, e_disc, 1, 1);
                value_errors++;
            end
        end
    endtask

    initial begin
        int total_gap;
        int extra;
        i_clk       = 1'b0;
        i_rst       = 1'b1;
        i_tag_valid = '0;
        i_tag       = '0;
        total_gap   = 0;
        void'($urandom(32'h6a6ab17d));
        load_cases();
        if (cases.size() == 0) begin
            $display("no cases were loaded");
            other_errors++;
        end
        foreach (cases[i]) total_gap += int'(cases[i].gap);
        timeout_limit = total_gap + 20 * cases.size() + 1000;
        repeat (10) @(negedge i_clk);
        i_rst = 1'b0;
        foreach (cases[i]) begin
            extra = cases[i].filler ? int'($urandom % 4) : 0;  // timer-sensitive cases keep exact gaps
            idle_cycles(int'(cases[i].gap) + extra);
            run_case(cases[i], i);
        end
        idle_cycles(10);
        $display("summary: %0d cases, %0d value errors, %0d other errors",
                 cases.size(), value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/recovery_cases.txt
# gap flag mask h0 s0 h1 s1 h2 s2 h3 s3 codes (gap and flag decimal, the rest hex)
# flag 1 allows random idle filler; codes port 0 first: P pass D discard N none E pair - idle
2 1 1 1 0010 0 0000 0 0000 0 0000 P---
2 1 2 0 0000 1 0010 0 0000 0 0000 -D--
2 1 4 0 0000 0 0000 2 0100 0 0000 --P-
2 1 8 0 0000 0 0000 0 0000 2 0100 ---D
# new number passes, old one no longer matches
2 1 1 1 0011 0 0000 0 0000 0 0000 P---
2 1 2 0 0000 1 0010 0 0000 0 0000 -P--
2 1 4 0 0000 0 0000 1 0010 0 0000 --D-
# invalid sequence leaves the stored number and take-any alone
2 1 8 0 0000 0 0000 0 0000 1 ffff ---N
2 1 1 1 0010 0 0000 0 0000 0 0000 D---
2 1 2 0 0000 7 ffff 0 0000 0 0000 -N--
2 1 2 0 0000 7 0500 0 0000 0 0000 -P--
2 1 2 0 0000 7 0500 0 0000 0 0000 -D--
# several ports in one cycle
2 1 5 3 0200 0 0000 3 0200 0 0000 E-E-
2 1 a 0 0000 4 0400 0 0000 5 0500 -P-P
2 1 f 4 0400 3 0201 5 ffff 3 0201 DENE
# timer expiry, exact gaps
2 0 1 6 0300 0 0000 0 0000 0 0000 P---
2 0 2 0 0000 6 0300 0 0000 0 0000 -D--
80 0 4 0 0000 0 0000 6 0300 0 0000 --P-
30 0 8 0 0000 0 0000 0 0000 6 0300 ---D
2 0 1 1 0010 0 0000 0 0000 0 0000 P---
2 0 2 0 0000 1 0010 0 0000 0 0000 -D--

// File: flist.f
hdl/frer_pkg.sv
hdl/tag_capture.sv
hdl/recovery_ctrl.sv
hdl/stream_table.sv
hdl/stream_timer_bank.sv
hdl/match_recovery_top.sv
verification/match_recovery_assert.sv
verification/tb_match_recovery.sv

// File: run_sim.sh
#!/bin/sh
# build and run the match recovery testbench with Verilator, from the project root
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_match_recovery -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_match_recovery > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "result: fail"
    exit 1
fi
echo "result: pass"
exit 0
